//--- hdl/ooo_cfg.svh
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// Data word width
`define OOO_XLEN 32

// Physical register index width, 128 registers
`define OOO_PREG_W 7

// ROB tag width, 16 slots
`define OOO_ROB_W 4

// Entries in the ALU reservation station
`define OOO_RS_DEPTH 8

`endif

//--- hdl/ooo_pkg.sv
`include "ooo_cfg.svh"

package ooo_pkg;

  typedef logic [`OOO_XLEN-1:0]   xlen_t;
  typedef logic [`OOO_PREG_W-1:0] preg_t;
  typedef logic [`OOO_ROB_W-1:0]  rob_tag_t;

  // SLT compares signed, shifts take the low 5 bits of operand two
  typedef enum logic [2:0] {
    ADD, SUB, AND, OR, XOR, SLL, SRL, SLT
  } alu_op_e;

  // Renamed instruction as it arrives at dispatch
  typedef struct packed {
    preg_t   prs1;
    preg_t   prs2;
    preg_t   prd;
    alu_op_e op;
    xlen_t   imm;
    logic    use_imm;
  } dispatch_t;

  // Common data bus broadcast
  typedef struct packed {
    logic     valid;
    rob_tag_t tag;
    preg_t    prd;
    xlen_t    data;
  } cdb_t;

endpackage

//--- hdl/pipe_skid_buffer.sv
module pipe_skid_buffer (
  input  logic               clk,
  input  logic               rst,
  input  logic               i_valid,
  output logic               o_ready,
  input  ooo_pkg::dispatch_t i_data,
  output logic               o_valid,
  input  logic               i_ready,
  output ooo_pkg::dispatch_t o_data
);

  logic               skid_valid;
  ooo_pkg::dispatch_t skid_data;
  logic               accept;

  // Ready comes straight from a flop, low only while the skid slot is taken
  assign o_ready = ~skid_valid;
  assign accept  = i_valid & o_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (!o_valid || i_ready) begin
      // Output slot drains, refill from skid first
      o_valid    <= skid_valid | accept;
      skid_valid <= 1'b0;
    end else if (accept) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!o_valid || i_ready) begin
      o_data <= skid_valid ? skid_data : i_data;
    end else if (accept) begin
      skid_data <= i_data;
    end
  end

endmodule

//--- hdl/dispatch_scoreboard.sv
`include "ooo_cfg.svh"

module dispatch_scoreboard (
  input  logic               clk,
  input  logic               rst,
  input  logic               i_valid,
  output logic               o_ready,
  input  ooo_pkg::dispatch_t i_inst,
  input  logic               i_rob_full,
  input  logic               i_rs_full,
  input  ooo_pkg::cdb_t      i_cdb,
  output logic               o_alloc,
  output logic               o_src1_ready,
  output logic               o_src2_ready
);

  // One busy bit per physical register, set while a result is pending
  logic [2**`OOO_PREG_W-1:0] busy;

  assign o_ready = ~i_rob_full & ~i_rs_full;
  assign o_alloc = i_valid & o_ready;

  // A source being written on the CDB this cycle counts as ready
  assign o_src1_ready = (i_inst.prs1 == '0) || !busy[i_inst.prs1] ||
                        (i_cdb.valid && i_cdb.prd == i_inst.prs1);
  assign o_src2_ready = (i_inst.prs2 == '0) || !busy[i_inst.prs2] ||
                        (i_cdb.valid && i_cdb.prd == i_inst.prs2);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= '0;
    end else begin
      if (i_cdb.valid && i_cdb.prd != '0) begin
        busy[i_cdb.prd] <= 1'b0;
      end
      // New allocation wins over a completing older writer
      if (o_alloc && i_inst.prd != '0) begin
        busy[i_inst.prd] <= 1'b1;
      end
    end
  end

endmodule

//--- hdl/alu_reservation_station.sv
`include "ooo_cfg.svh"

module alu_reservation_station (
  input  logic               clk,
  input  logic               rst,
  input  logic               i_alloc,
  input  ooo_pkg::dispatch_t i_inst,
  input  ooo_pkg::rob_tag_t  i_tag,
  input  logic               i_src1_ready,
  input  logic               i_src2_ready,
  input  ooo_pkg::cdb_t      i_cdb,
  output logic               o_full,
  output logic               o_issue_valid,
  output ooo_pkg::preg_t     o_issue_prs1,
  output ooo_pkg::preg_t     o_issue_prs2,
  output ooo_pkg::preg_t     o_issue_prd,
  output ooo_pkg::rob_tag_t  o_issue_tag,
  output ooo_pkg::alu_op_e   o_issue_op,
  output ooo_pkg::xlen_t     o_issue_imm,
  output logic               o_issue_use_imm
);

  typedef logic [$clog2(`OOO_RS_DEPTH)-1:0] rs_idx_t;

  logic [`OOO_RS_DEPTH-1:0] ent_valid;
  logic [`OOO_RS_DEPTH-1:0] ent_rdy1;
  logic [`OOO_RS_DEPTH-1:0] ent_rdy2;
  logic [`OOO_RS_DEPTH-1:0] ent_ready;
  ooo_pkg::dispatch_t       ent_inst [`OOO_RS_DEPTH];
  ooo_pkg::rob_tag_t        ent_tag  [`OOO_RS_DEPTH];
  rs_idx_t                  free_idx;
  rs_idx_t                  issue_idx;

  // ==========================================================================
  // Entry select
  // ==========================================================================
  assign ent_ready = ent_valid & ent_rdy1 & ent_rdy2;

  // Scan downwards so the lowest matching index is left standing
  always_comb begin
    free_idx  = '0;
    issue_idx = '0;
    for (int i = `OOO_RS_DEPTH - 1; i >= 0; i--) begin
      if (!ent_valid[i]) free_idx = rs_idx_t'(i);
      if (ent_ready[i])  issue_idx = rs_idx_t'(i);
    end
  end

  assign o_full          = &ent_valid;
  assign o_issue_valid   = |ent_ready;
  assign o_issue_prs1    = ent_inst[issue_idx].prs1;
  assign o_issue_prs2    = ent_inst[issue_idx].prs2;
  assign o_issue_prd     = ent_inst[issue_idx].prd;
  assign o_issue_op      = ent_inst[issue_idx].op;
  assign o_issue_imm     = ent_inst[issue_idx].imm;
  assign o_issue_use_imm = ent_inst[issue_idx].use_imm;
  assign o_issue_tag     = ent_tag[issue_idx];

  // ==========================================================================
  // Wakeup, issue and allocation
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      ent_valid <= '0;
      ent_rdy1  <= '0;
      ent_rdy2  <= '0;
    end else begin
      for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
        if (i_cdb.valid && ent_valid[i]) begin
          if (ent_inst[i].prs1 == i_cdb.prd) ent_rdy1[i] <= 1'b1;
          if (ent_inst[i].prs2 == i_cdb.prd) ent_rdy2[i] <= 1'b1;
        end
      end
      if (o_issue_valid) begin
        ent_valid[issue_idx] <= 1'b0;
      end
      // Free slot never equals the issuing one, so these never collide
      if (i_alloc) begin
        ent_valid[free_idx] <= 1'b1;
        ent_rdy1[free_idx]  <= i_src1_ready;
        ent_rdy2[free_idx]  <= i_src2_ready;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_alloc) begin
      ent_inst[free_idx] <= i_inst;
      ent_tag[free_idx]  <= i_tag;
    end
  end

endmodule

//--- hdl/phys_reg_file.sv
`include "ooo_cfg.svh"

module phys_reg_file (
  input  logic           clk,
  input  logic           rst,
  input  ooo_pkg::preg_t i_rd_addr1,
  input  ooo_pkg::preg_t i_rd_addr2,
  output ooo_pkg::xlen_t o_rd_data1,
  output ooo_pkg::xlen_t o_rd_data2,
  input  ooo_pkg::cdb_t  i_cdb
);

  ooo_pkg::xlen_t regs [2**`OOO_PREG_W];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**`OOO_PREG_W; i++) regs[i] <= '0;
    end else if (i_cdb.valid && i_cdb.prd != '0) begin
      regs[i_cdb.prd] <= i_cdb.data;
    end
  end

  // Register 0 is hardwired to zero
  assign o_rd_data1 = (i_rd_addr1 == '0) ? '0 : regs[i_rd_addr1];
  assign o_rd_data2 = (i_rd_addr2 == '0) ? '0 : regs[i_rd_addr2];

endmodule

//--- hdl/alu_exec.sv
module alu_exec (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_valid,
  input  ooo_pkg::alu_op_e  i_op,
  input  ooo_pkg::xlen_t    i_op1,
  input  ooo_pkg::xlen_t    i_op2_reg,
  input  ooo_pkg::xlen_t    i_imm,
  input  logic              i_use_imm,
  input  ooo_pkg::preg_t    i_prd,
  input  ooo_pkg::rob_tag_t i_tag,
  output ooo_pkg::cdb_t     o_cdb
);

  ooo_pkg::xlen_t    op2;
  ooo_pkg::xlen_t    result;
  logic              valid_q;
  ooo_pkg::rob_tag_t tag_q;
  ooo_pkg::preg_t    prd_q;
  ooo_pkg::xlen_t    data_q;

  assign op2 = i_use_imm ? i_imm : i_op2_reg;

  always_comb begin
    case (i_op)
      ooo_pkg::ADD: result = i_op1 + op2;
      ooo_pkg::SUB: result = i_op1 - op2;
      ooo_pkg::AND: result = i_op1 & op2;
      ooo_pkg::OR:  result = i_op1 | op2;
      ooo_pkg::XOR: result = i_op1 ^ op2;
      ooo_pkg::SLL: result = i_op1 << op2[4:0];
      ooo_pkg::SRL: result = i_op1 >> op2[4:0];
      default:      result = ($signed(i_op1) < $signed(op2)) ? 1 : '0;
    endcase
  end

  // Single CDB driver, one cycle after issue
  always_ff @(posedge clk) begin
    if (rst) valid_q <= 1'b0;
    else     valid_q <= i_valid;
  end

  always_ff @(posedge clk) begin
    tag_q  <= i_tag;
    prd_q  <= i_prd;
    data_q <= result;
  end

  assign o_cdb = '{valid: valid_q, tag: tag_q, prd: prd_q, data: data_q};

endmodule

//--- hdl/reorder_buffer.sv
`include "ooo_cfg.svh"

module reorder_buffer (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_alloc,
  input  ooo_pkg::preg_t    i_prd,
  output ooo_pkg::rob_tag_t o_alloc_tag,
  output logic              o_full,
  input  ooo_pkg::cdb_t     i_cdb,
  output logic              o_commit_valid,
  output ooo_pkg::preg_t    o_commit_prd,
  output ooo_pkg::xlen_t    o_commit_data
);

  ooo_pkg::rob_tag_t       head;
  ooo_pkg::rob_tag_t       tail;
  logic [`OOO_ROB_W:0]     count;
  logic [2**`OOO_ROB_W-1:0] done;
  ooo_pkg::preg_t          slot_prd  [2**`OOO_ROB_W];
  ooo_pkg::xlen_t          slot_data [2**`OOO_ROB_W];

  assign o_alloc_tag    = tail;
  // Count MSB alone marks all 16 slots in use
  assign o_full         = count[`OOO_ROB_W];
  assign o_commit_valid = (count != '0) && done[head];
  assign o_commit_prd   = slot_prd[head];
  assign o_commit_data  = slot_data[head];

  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      done  <= '0;
    end else begin
      if (i_alloc) begin
        done[tail] <= 1'b0;
        tail       <= tail + 1'b1;
      end
      if (i_cdb.valid) done[i_cdb.tag] <= 1'b1;
      if (o_commit_valid) head <= head + 1'b1;
      count <= count + (`OOO_ROB_W + 1)'(i_alloc) - (`OOO_ROB_W + 1)'(o_commit_valid);
    end
  end

  always_ff @(posedge clk) begin
    if (i_alloc) slot_prd[tail] <= i_prd;
    if (i_cdb.valid) slot_data[i_cdb.tag] <= i_cdb.data;
  end

endmodule

//--- hdl/ooo_backend_top.sv
module ooo_backend_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_valid,
  input  ooo_pkg::preg_t   i_prs1,
  input  ooo_pkg::preg_t   i_prs2,
  input  ooo_pkg::preg_t   i_prd,
  input  ooo_pkg::alu_op_e i_op,
  input  ooo_pkg::xlen_t   i_imm,
  input  logic             i_use_imm,
  output logic             o_ready,
  output logic             o_commit_valid,
  output ooo_pkg::preg_t   o_commit_prd,
  output ooo_pkg::xlen_t   o_commit_data
);

  // ==========================================================================
  // Interconnect
  // ==========================================================================
  ooo_pkg::dispatch_t in_inst;
  ooo_pkg::dispatch_t disp_inst;
  logic               disp_valid;
  logic               disp_ready;
  logic               alloc;
  logic               src1_ready;
  logic               src2_ready;
  logic               rob_full;
  logic               rs_full;
  ooo_pkg::rob_tag_t  alloc_tag;
  ooo_pkg::cdb_t      cdb;

  logic               iss_valid;
  ooo_pkg::preg_t     iss_prs1;
  ooo_pkg::preg_t     iss_prs2;
  ooo_pkg::preg_t     iss_prd;
  ooo_pkg::rob_tag_t  iss_tag;
  ooo_pkg::alu_op_e   iss_op;
  ooo_pkg::xlen_t     iss_imm;
  logic               iss_use_imm;
  ooo_pkg::xlen_t     rf_data1;
  ooo_pkg::xlen_t     rf_data2;

  assign in_inst = '{prs1: i_prs1, prs2: i_prs2, prd: i_prd, op: i_op,
                     imm: i_imm, use_imm: i_use_imm};

  // ==========================================================================
  // Units
  // ==========================================================================
  pipe_skid_buffer u_skid (
    .clk(clk), .rst(rst),
    .i_valid(i_valid), .o_ready(o_ready), .i_data(in_inst),
    .o_valid(disp_valid), .i_ready(disp_ready), .o_data(disp_inst)
  );

  dispatch_scoreboard u_dispatch (
    .clk(clk), .rst(rst),
    .i_valid(disp_valid), .o_ready(disp_ready), .i_inst(disp_inst),
    .i_rob_full(rob_full), .i_rs_full(rs_full), .i_cdb(cdb),
    .o_alloc(alloc), .o_src1_ready(src1_ready), .o_src2_ready(src2_ready)
  );

  alu_reservation_station u_rs (
    .clk(clk), .rst(rst),
    .i_alloc(alloc), .i_inst(disp_inst), .i_tag(alloc_tag),
    .i_src1_ready(src1_ready), .i_src2_ready(src2_ready), .i_cdb(cdb),
    .o_full(rs_full), .o_issue_valid(iss_valid),
    .o_issue_prs1(iss_prs1), .o_issue_prs2(iss_prs2), .o_issue_prd(iss_prd),
    .o_issue_tag(iss_tag), .o_issue_op(iss_op), .o_issue_imm(iss_imm),
    .o_issue_use_imm(iss_use_imm)
  );

  phys_reg_file u_prf (
    .clk(clk), .rst(rst),
    .i_rd_addr1(iss_prs1), .i_rd_addr2(iss_prs2),
    .o_rd_data1(rf_data1), .o_rd_data2(rf_data2), .i_cdb(cdb)
  );

  alu_exec u_alu (
    .clk(clk), .rst(rst),
    .i_valid(iss_valid), .i_op(iss_op), .i_op1(rf_data1), .i_op2_reg(rf_data2),
    .i_imm(iss_imm), .i_use_imm(iss_use_imm), .i_prd(iss_prd), .i_tag(iss_tag),
    .o_cdb(cdb)
  );

  reorder_buffer u_rob (
    .clk(clk), .rst(rst),
    .i_alloc(alloc), .i_prd(disp_inst.prd), .o_alloc_tag(alloc_tag),
    .o_full(rob_full), .i_cdb(cdb),
    .o_commit_valid(o_commit_valid), .o_commit_prd(o_commit_prd),
    .o_commit_data(o_commit_data)
  );

endmodule

//--- tests/clk_gen.sv
module clk_gen (
  output logic clk
);

  timeunit 1ns;
  timeprecision 1ps;

  // 100 ns period, starts low
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

endmodule

//--- tests/ooo_backend_sva.sv
module ooo_backend_sva (
  input logic clk,
  input logic rst,
  input logic i_ready,
  input logic i_commit_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  // Failures so far, watched by the testbench
  int unsigned fail_count;

  initial fail_count = 0;

  // Skid, dispatch, issue and CDB stages lie between input and commit
  a_no_early_commit: assert property (@(posedge clk) $fell(rst) |-> !i_commit_valid [*3])
    else begin
      $error("commit within three cycles after reset");
      fail_count++;
    end

  a_commit_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(i_commit_valid))
    else begin
      $error("o_commit_valid is unknown");
      fail_count++;
    end

  a_ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> i_ready)
    else begin
      $error("o_ready low in the first cycle after reset");
      fail_count++;
    end

endmodule

bind ooo_backend_top ooo_backend_sva u_sva (
  .clk(clk), .rst(rst), .i_ready(o_ready), .i_commit_valid(o_commit_valid)
);

//--- tests/tb_ooo_backend.sv
`include "ooo_cfg.svh"

module tb_ooo_backend;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_LOAD  = 8;
  localparam int N_CHAIN = 10;
  localparam int N_ROUND = 4;
  localparam int N_BURST = 24;
  localparam int N_INSTR = N_LOAD + N_CHAIN + N_ROUND * 10 + N_BURST;

  logic             clk;
  logic             rst;
  logic             i_valid;
  ooo_pkg::preg_t   i_prs1;
  ooo_pkg::preg_t   i_prs2;
  ooo_pkg::preg_t   i_prd;
  ooo_pkg::alu_op_e i_op;
  ooo_pkg::xlen_t   i_imm;
  logic             i_use_imm;
  logic             o_ready;
  logic             o_commit_valid;
  ooo_pkg::preg_t   o_commit_prd;
  ooo_pkg::xlen_t   o_commit_data;

  // Architectural view of the register file, updated in send order
  ooo_pkg::xlen_t   model [2**`OOO_PREG_W];
  ooo_pkg::preg_t   exp_prd_q [$];
  ooo_pkg::xlen_t   exp_data_q [$];
  int               n_committed;
  logic             ready_dropped;

  clk_gen u_clk (.clk(clk));

  ooo_backend_top uut (.*);

  // ==========================================================================
  // Reference rules and checks
  // ==========================================================================
  function automatic ooo_pkg::xlen_t expected_result(ooo_pkg::alu_op_e op,
                                                     ooo_pkg::xlen_t a, ooo_pkg::xlen_t b);
    case (op)
      ooo_pkg::ADD: return a + b;
      ooo_pkg::SUB: return a - b;
      ooo_pkg::AND: return a & b;
      ooo_pkg::OR:  return a | b;
      ooo_pkg::XOR: return a ^ b;
      ooo_pkg::SLL: return a << b[4:0];
      ooo_pkg::SRL: return a >> b[4:0];
      default: begin
        // Signs differ, so the negative one is smaller
        if (a[31] != b[31]) return ooo_pkg::xlen_t'(a[31]);
        return ooo_pkg::xlen_t'(a < b);
      end
    endcase
  endfunction

  task automatic stop_run();
    $display("** FAIL **");
    $fatal(1, "Stopped at the first failure");
  endtask

  task automatic check_data(string what, ooo_pkg::xlen_t got, ooo_pkg::xlen_t exp);
    if (got !== exp) begin
      $display("ERROR at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      stop_run();
    end
  endtask

  task automatic check_preg(string what, ooo_pkg::preg_t got, ooo_pkg::preg_t exp);
    if (got !== exp) begin
      $display("ERROR at %0d ns: %s is p%0d, expected p%0d", $time, what, got, exp);
      stop_run();
    end
  endtask

  // Commits are stable mid-cycle
  always @(negedge clk) begin
    if (rst === 1'b0 && o_commit_valid === 1'b1) begin
      if (exp_prd_q.size() == 0) begin
        $display("Commit of p%0d at %0d ns with no instruction outstanding",
                 o_commit_prd, $time);
        stop_run();
      end
      check_preg("commit destination", o_commit_prd, exp_prd_q.pop_front());
      check_data("commit data", o_commit_data, exp_data_q.pop_front());
      n_committed++;
    end
  end

  // Bound assertions count their failures
  always @(uut.u_sva.fail_count) begin
    if (uut.u_sva.fail_count != 0) begin
      $display("A bound assertion failed at %0d ns", $time);
      stop_run();
    end
  end

  // ==========================================================================
  // Stimulus
  // ==========================================================================
  // Called 1 ns after a rising edge, returns at the same phase
  task automatic send(ooo_pkg::preg_t prs1, ooo_pkg::preg_t prs2, ooo_pkg::preg_t prd,
                      ooo_pkg::alu_op_e op, ooo_pkg::xlen_t imm, logic use_imm);
    ooo_pkg::xlen_t op2;
    ooo_pkg::xlen_t res;
    op2 = use_imm ? imm : model[prs2];
    res = expected_result(op, model[prs1], op2);
    if (prd != '0) model[prd] = res;
    exp_prd_q.push_back(prd);
    exp_data_q.push_back(res);
    i_valid   = 1'b1;
    i_prs1    = prs1;
    i_prs2    = prs2;
    i_prd     = prd;
    i_op      = op;
    i_imm     = imm;
    i_use_imm = use_imm;
    while (o_ready !== 1'b1) begin
      ready_dropped = 1'b1;
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    i_valid = 1'b0;
  endtask

  task automatic drain();
    do begin
      @(posedge clk);
    end while (exp_prd_q.size() != 0);
    #1;
  endtask

  function automatic ooo_pkg::preg_t loaded_reg();
    return ooo_pkg::preg_t'(1 + $urandom_range(N_LOAD - 1));
  endfunction

  // ==========================================================================
  // Directed tests
  // ==========================================================================
  task automatic test_reset_idle();
    if (o_ready !== 1'b1) begin
      $display("o_ready is not high after reset");
      stop_run();
    end
    repeat (6) @(posedge clk);
    #1;
    if (n_committed != 0) begin
      $display("A commit appeared before any instruction was sent");
      stop_run();
    end
  endtask

  task automatic test_imm_loads();
    for (int i = 0; i < N_LOAD; i++) begin
      send('0, '0, ooo_pkg::preg_t'(1 + i), ooo_pkg::ADD, $urandom(), 1'b1);
    end
    drain();
  endtask

  task automatic test_dep_chain();
    ooo_pkg::preg_t   prev;
    ooo_pkg::preg_t   src2;
    ooo_pkg::alu_op_e op;
    ooo_pkg::xlen_t   imm;
    logic             use_imm;
    prev = ooo_pkg::preg_t'(1);
    for (int i = 0; i < N_CHAIN; i++) begin
      src2    = loaded_reg();
      op      = ooo_pkg::alu_op_e'($urandom_range(7));
      imm     = $urandom();
      use_imm = 1'($urandom_range(1));
      send(prev, src2, ooo_pkg::preg_t'(10 + i), op, imm, use_imm);
      prev = ooo_pkg::preg_t'(10 + i);
    end
    drain();
  endtask

  task automatic test_all_ops();
    ooo_pkg::preg_t base;
    for (int r = 0; r < N_ROUND; r++) begin
      base = ooo_pkg::preg_t'(20 + 10 * r);
      send('0, '0, base, ooo_pkg::ADD, $urandom(), 1'b1);
      send('0, '0, ooo_pkg::preg_t'(base + 1), ooo_pkg::ADD, $urandom(), 1'b1);
      for (int k = 0; k < 8; k++) begin
        send(base, ooo_pkg::preg_t'(base + 1), ooo_pkg::preg_t'(base + 2 + k),
             ooo_pkg::alu_op_e'(k), '0, 1'b0);
      end
    end
    drain();
  endtask

  task automatic test_burst();
    ooo_pkg::preg_t   prev;
    ooo_pkg::preg_t   src2;
    ooo_pkg::alu_op_e op;
    ooo_pkg::xlen_t   imm;
    logic             use_imm;
    ready_dropped = 1'b0;
    prev = ooo_pkg::preg_t'(10 + N_CHAIN - 1);
    for (int i = 0; i < N_BURST; i++) begin
      src2    = loaded_reg();
      op      = ooo_pkg::alu_op_e'($urandom_range(7));
      imm     = $urandom();
      use_imm = 1'($urandom_range(1));
      send(prev, src2, ooo_pkg::preg_t'(64 + i), op, imm, use_imm);
      prev = ooo_pkg::preg_t'(64 + i);
    end
    if (!ready_dropped) begin
      $display("o_ready never dropped during the dependent burst");
      stop_run();
    end
    drain();
  endtask

  // ==========================================================================
  // Main sequence and watchdog
  // ==========================================================================
  initial begin
    void'($urandom(32'hbb940c0b));
    rst           = 1'b1;
    i_valid       = 1'b0;
    i_prs1        = '0;
    i_prs2        = '0;
    i_prd         = '0;
    i_op          = ooo_pkg::ADD;
    i_imm         = '0;
    i_use_imm     = 1'b0;
    n_committed   = 0;
    ready_dropped = 1'b0;
    foreach (model[i]) model[i] = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    test_reset_idle();
    test_imm_loads();
    test_dep_chain();
    test_all_ops();
    test_burst();

    $display("** PASS **");
    $finish;
  end

  initial begin
    repeat (40 * N_INSTR + 100) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", 40 * N_INSTR + 100);
    stop_run();
  end

endmodule

//--- tb.f
+incdir+hdl
hdl/ooo_pkg.sv
hdl/pipe_skid_buffer.sv
hdl/dispatch_scoreboard.sv
hdl/alu_reservation_station.sv
hdl/phys_reg_file.sv
hdl/alu_exec.sv
hdl/reorder_buffer.sv
hdl/ooo_backend_top.sv
tests/clk_gen.sv
tests/ooo_backend_sva.sv
tests/tb_ooo_backend.sv

//--- Bender.yml
package:
  name: ooo_backend

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ooo_pkg.sv
      - hdl/pipe_skid_buffer.sv
      - hdl/dispatch_scoreboard.sv
      - hdl/alu_reservation_station.sv
      - hdl/phys_reg_file.sv
      - hdl/alu_exec.sv
      - hdl/reorder_buffer.sv
      - hdl/ooo_backend_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/clk_gen.sv
      - tests/ooo_backend_sva.sv
      - tests/tb_ooo_backend.sv
